/* design/spim_types_pkg.sv */
// SPI master data path types
// word, counter and select widths, plus the engine state encoding
package spim_types_pkg;

	localparam int DATA_W     = 32;	// spi word and apb data width
	localparam int BIT_CNT_W  = 5;	// bit index within a word
	localparam int BURST_W    = 14;	// words per burst
	localparam int SSEL_W     = 2;	// one of four slaves
	localparam int APB_ADDR_W = 8;	// byte address space of the block

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;
	typedef logic [BURST_W-1:0]    burst_len_t;
	typedef logic [SSEL_W-1:0]     ssel_t;
	typedef logic [APB_ADDR_W-1:0] apb_addr_t;

	// engine sequence, select -> shift -> last word -> release
	typedef enum logic [2:0] {
		st_idle,
		st_select,	// first bit of word 0 on the line
		st_shift,	// middle words
		st_last,	// final word of the burst
		st_release	// slave select back high
	} spim_state_e;

endpackage

/* design/spim_regs_pkg.sv */
// SPI master APB register map
// offsets of control registers and buffer windows, field bit positions
package spim_regs_pkg;

	import spim_types_pkg::*;

	// control and status registers
	localparam apb_addr_t REG_CTRL   = 8'h00;
	localparam apb_addr_t REG_BURST  = 8'h04;
	localparam apb_addr_t REG_STATUS = 8'h08;

	// buffer windows, word k at base + 4k
	localparam apb_addr_t TXBUF_BASE = 8'h40;
	localparam apb_addr_t RXBUF_BASE = 8'h80;
	localparam apb_addr_t BUF_SPAN   = 8'h40;	// 16 words per window
	localparam int        BUF_IDX_LSB = 2;
	localparam int        BUF_IDX_W   = 4;

	// CTRL fields
	localparam int CTRL_START_BIT = 0;	// write only, reads 0
	localparam int CTRL_SSEL_LSB  = 1;

	// STATUS fields
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_DONE_BIT = 1;	// write one to clear

endpackage

/* design/spim_apb_regs.sv */
// SPI master APB slave
// control, burst and status registers plus decode into the tx and rx buffers
`timescale 1ns/1ps

module spim_apb_regs import spim_types_pkg::*, spim_regs_pkg::*; #(
	parameter  int BUF_DEPTH = 16,
	localparam int IDX_W     = $clog2(BUF_DEPTH)
) (
	input  logic             sclk_in,
	input  logic             rst_n,
	input  apb_addr_t        paddr,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  word_t            pwdata,
	output word_t            prdata,
	output logic             pready,
	output logic             pslverr,
	output logic             tx_we,
	output logic [IDX_W-1:0] tx_waddr,
	output word_t            tx_wdata,
	output logic [IDX_W-1:0] rx_raddr,
	input  word_t            rx_rdata,
	output logic             start,
	output burst_len_t       brstlen,
	output ssel_t            sselect,
	input  logic             busy,
	input  logic             done,
	output logic             irq
);

logic                 access;
logic                 aligned;
logic [BUF_IDX_W-1:0] buf_idx;
logic                 is_ctrl, is_burst, is_status, is_reg;
logic                 in_tx, in_rx, idx_ok;
logic                 addr_err;
logic                 wr_ok;
logic                 done_flag;
word_t                rd_mux;
word_t                tx_copy [BUF_DEPTH];	// mirror of the tx buffer for bus reads

////////////////////////////////////////////////////////////
// address decode
////////////////////////////////////////////////////////////
assign access  = psel & penable;	// second cycle of the transfer
assign aligned = (paddr[1:0] == 2'b00);
assign buf_idx = paddr[BUF_IDX_LSB +: BUF_IDX_W];

assign is_ctrl   = (paddr == REG_CTRL);
assign is_burst  = (paddr == REG_BURST);
assign is_status = (paddr == REG_STATUS);
assign is_reg    = is_ctrl | is_burst | is_status;

assign in_tx  = (paddr >= TXBUF_BASE) && (paddr < TXBUF_BASE + BUF_SPAN);
assign in_rx  = (paddr >= RXBUF_BASE) && (paddr < RXBUF_BASE + BUF_SPAN);
assign idx_ok = (int'(buf_idx) < BUF_DEPTH);

// rx window is read only from the bus
assign addr_err = ~aligned | ~(is_reg | ((in_tx | in_rx) & idx_ok)) | (in_rx & pwrite);

assign pready  = 1'b1;	// no wait states
assign pslverr = access & addr_err;
assign wr_ok   = access & pwrite & ~addr_err;

// buffer ports
assign tx_we    = wr_ok & in_tx;
assign tx_waddr = buf_idx[IDX_W-1:0];
assign tx_wdata = pwdata;
assign rx_raddr = buf_idx[IDX_W-1:0];

////////////////////////////////////////////////////////////
// read data
////////////////////////////////////////////////////////////
always_comb begin
	rd_mux = '0;
	if (is_ctrl) begin
		rd_mux[CTRL_SSEL_LSB +: SSEL_W] = sselect;
	end else if (is_burst) begin
		rd_mux[BURST_W-1:0] = brstlen;
	end else if (is_status) begin
		rd_mux[STAT_BUSY_BIT] = busy;
		rd_mux[STAT_DONE_BIT] = done_flag;
	end else if (in_rx) begin
		rd_mux = rx_rdata;
	end else if (in_tx) begin
		rd_mux = tx_copy[tx_waddr];	// engine owns the buffer read port
	end
end

assign prdata = rd_mux;

// tx words as written by the bus
always_ff @(posedge sclk_in or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < BUF_DEPTH; i++) begin
			tx_copy[i] <= '0;
		end
	end else if (tx_we) begin
		tx_copy[tx_waddr] <= tx_wdata;
	end
end

////////////////////////////////////////////////////////////
// registers
////////////////////////////////////////////////////////////
always_ff @(posedge sclk_in or negedge rst_n) begin
	if (!rst_n) begin
		start     <= 1'b0;
		sselect   <= '0;
		brstlen   <= burst_len_t'(1);
		done_flag <= 1'b0;
	end else begin
		// one cycle pulse, dropped when a burst is already running
		start <= wr_ok & is_ctrl & pwdata[CTRL_START_BIT] & ~busy & ~start;

		if (wr_ok && is_ctrl && !busy)
			sselect <= pwdata[CTRL_SSEL_LSB +: SSEL_W];	// frozen during a burst
		if (wr_ok && is_burst && !busy)
			brstlen <= pwdata[BURST_W-1:0];

		if (done)
			done_flag <= 1'b1;	// set beats clear
		else if (wr_ok && is_status && pwdata[STAT_DONE_BIT])
			done_flag <= 1'b0;
	end
end

assign irq = done_flag;

endmodule

/* design/spim_word_buf.sv */
// word buffer for the SPI master
// one synchronous write port and one combinational read port
`timescale 1ns/1ps

module spim_word_buf import spim_types_pkg::*; #(
	parameter  int BUF_DEPTH = 16,
	localparam int IDX_W     = $clog2(BUF_DEPTH)
) (
	input  logic             sclk_in,
	input  logic             rst_n,
	input  logic             we,
	input  logic [IDX_W-1:0] waddr,
	input  word_t            wdata,
	input  logic [IDX_W-1:0] raddr,
	output word_t            rdata
);

word_t mem [BUF_DEPTH];

////////////////////////////////////////////////////////////
// write port
////////////////////////////////////////////////////////////
always_ff @(posedge sclk_in or negedge rst_n) begin
	if (!rst_n) begin
		// buffer comes up all zero
		for (int i = 0; i < BUF_DEPTH; i++) begin
			mem[i] <= '0;
		end
	end else if (we) begin
		mem[waddr] <= wdata;
	end
end

////////////////////////////////////////////////////////////
// read port
////////////////////////////////////////////////////////////

// no output register, data follows raddr in the same cycle
// a write shows up here from the next cycle on
assign rdata = mem[raddr];

endmodule

/* design/spim_intf.sv */
// SPI master engine, mode 0, MSB first, full duplex
// mosi and slave selects change on the falling edge, miso sampled on the rising edge
`timescale 1ns/1ps

module spim_intf import spim_types_pkg::*; #(
	parameter  int BUF_DEPTH = 16,
	localparam int IDX_W     = $clog2(BUF_DEPTH)
) (
	input  logic             sclk_in,
	input  logic             rst_n,
	input  logic             start,
	input  burst_len_t       brstlen,
	input  ssel_t            sselect,
	output logic [IDX_W-1:0] tx_raddr,
	input  word_t            tx_rdata,
	output logic             rx_we,
	output logic [IDX_W-1:0] rx_waddr,
	output word_t            rx_wdata,
	output logic             busy,
	output logic             done,
	output logic             sclk,
	output logic             mosi,
	input  logic             miso,
	output logic             ss_n_0,
	output logic             ss_n_1,
	output logic             ss_n_2,
	output logic             ss_n_3
);

spim_state_e state, state_nxt;
bit_cnt_t    bit_cnt;	// bit now on mosi, 31 down to 0
burst_len_t  word_cnt;	// words still to come after the current one
word_t       tx_shift;
word_t       tx_pre;	// next word, fetched early
logic        shifting;
logic        sel_nxt;
logic        ss_all_n;
bit_cnt_t    rx_bit;
word_t       rx_shift;

assign sclk = sclk_in;	// forwarded, idles low between edges of interest

////////////////////////////////////////////////////////////
// state machine, falling edge
////////////////////////////////////////////////////////////
always_comb begin
	state_nxt = state;
	case (state)
		st_idle:    if (start) state_nxt = st_select;
		st_select:  state_nxt = (word_cnt == '0) ? st_last : st_shift;
		st_shift:   if (bit_cnt == '0 && word_cnt == burst_len_t'(1)) state_nxt = st_last;
		st_last:    if (bit_cnt == '0) state_nxt = st_release;
		st_release: state_nxt = st_idle;
		default:    state_nxt = st_idle;
	endcase
end

assign shifting = (state == st_select) || (state == st_shift) || (state == st_last);
assign sel_nxt  = (state_nxt == st_select) || (state_nxt == st_shift) ||
		  (state_nxt == st_last);
assign busy     = (state != st_idle);

always_ff @(negedge sclk_in or negedge rst_n) begin
	if (!rst_n) begin
		state    <= st_idle;
		bit_cnt  <= '0;
		word_cnt <= '0;
		tx_raddr <= '0;
		tx_shift <= '0;	// keeps mosi low out of reset
		done     <= 1'b0;
	end else begin
		state <= state_nxt;
		done  <= (state == st_release);	// one cycle after ss_n rises

		case (state)
			st_idle: begin
				if (start) begin
					tx_shift <= tx_rdata;	// word 0, bit 31 goes out now
					tx_raddr <= tx_raddr + 1'b1;
					bit_cnt  <= '1;
					word_cnt <= (brstlen == '0) ? '0 : brstlen - 1'b1;
				end
			end
			st_release: begin
				tx_raddr <= '0;
			end
			default: begin
				if (bit_cnt == '1)
					tx_raddr <= tx_raddr + 1'b1;	// moves past the preloaded word

				if (bit_cnt == '0) begin
					// word boundary, next word follows with no gap
					tx_shift <= (state == st_last) ? '0 : tx_pre;
					bit_cnt  <= '1;
					if (state == st_shift)
						word_cnt <= word_cnt - 1'b1;
				end else begin
					tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
					bit_cnt  <= bit_cnt - 1'b1;
				end
			end
		endcase
	end
end

// fetch word k+1 during the first bit of word k
always_ff @(negedge sclk_in) begin
	if (shifting && bit_cnt == '1)
		tx_pre <= tx_rdata;
end

assign mosi = tx_shift[DATA_W-1];

////////////////////////////////////////////////////////////
// slave selects, falling edge
////////////////////////////////////////////////////////////
always_ff @(negedge sclk_in or negedge rst_n) begin
	if (!rst_n) begin
		ss_n_0 <= 1'b1;
		ss_n_1 <= 1'b1;
		ss_n_2 <= 1'b1;
		ss_n_3 <= 1'b1;
	end else begin
		ss_n_0 <= ~(sel_nxt && sselect == ssel_t'(0));
		ss_n_1 <= ~(sel_nxt && sselect == ssel_t'(1));
		ss_n_2 <= ~(sel_nxt && sselect == ssel_t'(2));
		ss_n_3 <= ~(sel_nxt && sselect == ssel_t'(3));
	end
end

assign ss_all_n = ss_n_0 & ss_n_1 & ss_n_2 & ss_n_3;

////////////////////////////////////////////////////////////
// receive path, rising edge
////////////////////////////////////////////////////////////
always_ff @(posedge sclk_in or negedge rst_n) begin
	if (!rst_n) begin
		rx_bit   <= '0;
		rx_we    <= 1'b0;
		rx_waddr <= '0;
	end else begin
		rx_we <= !ss_all_n && (rx_bit == '1);	// last bit of a word captured

		if (ss_all_n)
			rx_bit <= '0;
		else
			rx_bit <= rx_bit + 1'b1;	// wraps at the word boundary

		if (rx_we)
			rx_waddr <= rx_waddr + 1'b1;
		else if (ss_all_n)
			rx_waddr <= '0;
	end
end

always_ff @(posedge sclk_in) begin
	if (!ss_all_n) begin
		rx_shift <= {rx_shift[DATA_W-2:0], miso};	// MSB arrives first
		if (rx_bit == '1)
			rx_wdata <= {rx_shift[DATA_W-2:0], miso};
	end
end

endmodule

/* design/spim_top.sv */
// SPI master subsystem top
// APB registers, transmit and receive word buffers, and the SPI engine
`timescale 1ns/1ps

module spim_top import spim_types_pkg::*; #(
	parameter  int BUF_DEPTH = 16,
	localparam int IDX_W     = $clog2(BUF_DEPTH)
) (
	input  logic      sclk_in,
	input  logic      rst_n,
	// APB slave
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  word_t     pwdata,
	output word_t     prdata,
	output logic      pready,
	output logic      pslverr,
	// SPI pins
	output logic      sclk,
	output logic      mosi,
	input  logic      miso,
	output logic      ss_n_0,
	output logic      ss_n_1,
	output logic      ss_n_2,
	output logic      ss_n_3,
	output logic      irq
);

logic             tx_we;
logic [IDX_W-1:0] tx_waddr;
word_t            tx_wdata;
logic [IDX_W-1:0] tx_raddr;
word_t            tx_rdata;
logic             rx_we;
logic [IDX_W-1:0] rx_waddr;
word_t            rx_wdata;
logic [IDX_W-1:0] rx_raddr;
word_t            rx_rdata;
logic             start;
logic             busy;
logic             done;
burst_len_t       brstlen;
ssel_t            sselect;

spim_apb_regs #(.BUF_DEPTH(BUF_DEPTH)) u_regs (
	.sclk_in, .rst_n,
	.paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
	.tx_we, .tx_waddr, .tx_wdata, .rx_raddr, .rx_rdata,
	.start, .brstlen, .sselect, .busy, .done, .irq
);

// filled over APB, drained by the engine
spim_word_buf #(.BUF_DEPTH(BUF_DEPTH)) u_tx_buf (
	.sclk_in, .rst_n,
	.we(tx_we), .waddr(tx_waddr), .wdata(tx_wdata),
	.raddr(tx_raddr), .rdata(tx_rdata)
);

// filled by the engine, read back over APB
spim_word_buf #(.BUF_DEPTH(BUF_DEPTH)) u_rx_buf (
	.sclk_in, .rst_n,
	.we(rx_we), .waddr(rx_waddr), .wdata(rx_wdata),
	.raddr(rx_raddr), .rdata(rx_rdata)
);

spim_intf #(.BUF_DEPTH(BUF_DEPTH)) u_spim (
	.sclk_in, .rst_n,
	.start, .brstlen, .sselect,
	.tx_raddr, .tx_rdata, .rx_we, .rx_waddr, .rx_wdata,
	.busy, .done,
	.sclk, .mosi, .miso, .ss_n_0, .ss_n_1, .ss_n_2, .ss_n_3
);

endmodule

/* dv/spim_checker.sv */
// SPI master checker
// rebuilds mosi words, watches slave selects and irq, compares APB read data
`timescale 1ns/1ps

module spim_checker import spim_types_pkg::*; #(
	parameter int BUF_DEPTH = 16
) (
	input logic  sclk_in,
	input logic  rst_n,
	input logic  sclk,
	input logic  mosi,
	input logic  ss_n_0,
	input logic  ss_n_1,
	input logic  ss_n_2,
	input logic  ss_n_3,
	input logic  irq,
	input word_t prdata,
	input logic  pready,
	input logic  pslverr
);

word_t      exp_mosi [BUF_DEPTH];
int         exp_len  = 0;
logic [3:0] exp_ss   = 4'hf;
int         bit_cnt  = 0;
int         word_cnt = 0;
int         bursts   = 0;
int         err_cnt  = 0;
word_t      shift    = '0;
logic       was_low  = 1'b0;
logic [3:0] ss;

assign ss = {ss_n_3, ss_n_2, ss_n_1, ss_n_0};

////////////////////////////////////////////////////////////
// spi bus monitor, sampled on the rising edge of the spi clock
////////////////////////////////////////////////////////////
always @(posedge sclk) begin
	if (rst_n && ss != 4'hf) begin
		if (ss !== exp_ss) begin
			$display("** Error: ss_n got %h expected %h", ss, exp_ss);
			err_cnt++;
		end
		shift = {shift[DATA_W-2:0], mosi};	// MSB first
		bit_cnt++;
		if (bit_cnt % DATA_W == 0) begin
			if (word_cnt < exp_len && shift !== exp_mosi[word_cnt]) begin
				$display("** Error: mosi word %0d got %h expected %h",
					word_cnt, shift, exp_mosi[word_cnt]);
				err_cnt++;
			end
			word_cnt++;
		end
		was_low = 1'b1;
	end else if (was_low) begin
		was_low = 1'b0;	// slave select just released
		bursts++;
		if (bit_cnt != DATA_W * exp_len) begin
			$display("burst shifted %0d bits while selected, expected %0d",
				bit_cnt, DATA_W * exp_len);
			err_cnt++;
		end
	end
end

// set up for one burst
task automatic arm(input int len, input int sel);
	exp_len  = len;
	exp_ss   = ~(4'b0001 << sel);
	bit_cnt  = 0;
	word_cnt = 0;
	bursts   = 0;
endtask

task automatic compare_apb(input logic wr, input apb_addr_t a, input word_t exp,
		input logic exp_err);
	if (pready !== 1'b1) begin
		$display("** Error: pready at %h got %h expected %h", a, pready, 1'b1);
		err_cnt++;
	end
	if (pslverr !== exp_err) begin
		$display("** Error: pslverr at %h got %h expected %h", a, pslverr, exp_err);
		err_cnt++;
	end
	if (!wr && !exp_err && prdata !== exp) begin
		$display("** Error: prdata at %h got %h expected %h", a, prdata, exp);
		err_cnt++;
	end
endtask

task automatic verify_pins(input logic [3:0] ss_exp, input logic irq_exp);
	if (ss !== ss_exp) begin
		$display("** Error: ss_n got %h expected %h", ss, ss_exp);
		err_cnt++;
	end
	if (irq !== irq_exp) begin
		$display("** Error: irq got %h expected %h", irq, irq_exp);
		err_cnt++;
	end
	if (mosi !== 1'b0) begin
		$display("** Error: mosi got %h expected %h", mosi, 1'b0);
		err_cnt++;
	end
endtask

task automatic expect_bursts(input int n);
	if (bursts != n) begin
		$display("saw %0d bursts where %0d were expected", bursts, n);
		err_cnt++;
	end
endtask

endmodule

/* dv/tb_top.sv */
// SPI master testbench
// APB driver, SPI slave model and stimulus records read from the input file
`timescale 1ns/1ps

module tb_top import spim_types_pkg::*, spim_regs_pkg::*; ();

localparam int BUF_DEPTH = 16;
localparam int REC_W     = 8;	// words per record
localparam int MAX_REC   = 8;

logic      sclk_in;
logic      rst_n;
apb_addr_t paddr;
logic      psel, penable, pwrite;
word_t     pwdata, prdata;
logic      pready, pslverr;
logic      sclk, mosi, miso;
logic      ss_n_0, ss_n_1, ss_n_2, ss_n_3;
logic      irq;

word_t recs [REC_W*MAX_REC];
word_t reply [BUF_DEPTH];
word_t rng = 32'd88976;
int    rx_n = 0;
int    tb_err = 0;

spim_top #(.BUF_DEPTH(BUF_DEPTH)) u_dut (.*);
spim_checker #(.BUF_DEPTH(BUF_DEPTH)) u_chk (.*);

initial begin
	sclk_in = 1'b0;
	forever #2 sclk_in = ~sclk_in;
end

////////////////////////////////////////////////////////////
// slave model, reply bits counted on captures
////////////////////////////////////////////////////////////
always @(posedge sclk_in) begin
	if (ss_n_0 & ss_n_1 & ss_n_2 & ss_n_3)
		rx_n <= 0;
	else
		rx_n <= rx_n + 1;
end

always @(negedge sclk_in) begin
	if (rx_n < DATA_W * BUF_DEPTH)
		miso <= reply[rx_n / DATA_W][DATA_W-1 - rx_n % DATA_W];
	else
		miso <= 1'b0;
end

function automatic word_t lcg_next(input word_t s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// one setup cycle and one access cycle, result checked mid access cycle
task automatic apb_access(input logic wr, input apb_addr_t a, input word_t d,
		input logic exp_err);
	@(negedge sclk_in);
	paddr   = a;
	pwrite  = wr;
	pwdata  = wr ? d : '0;
	psel    = 1'b1;
	penable = 1'b0;
	@(negedge sclk_in);
	penable = 1'b1;
	#1;
	u_chk.compare_apb(wr, a, d, exp_err);
	@(negedge sclk_in);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic wait_irq(input int limit);
	int i;
	for (i = 0; i < limit && irq !== 1'b1; i++)
		@(negedge sclk_in);
	if (irq !== 1'b1) begin
		$display("timeout: irq did not rise within %0d cycles", limit);
		tb_err++;
	end
endtask

initial begin
	int r, k, len, sel, last_len, last_sel, errs0, n_pass, n_fail;
	word_t txw;

	paddr = '0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	pwdata = '0;
	miso = 1'b0;
	n_pass = 0;
	n_fail = 0;
	last_len = 1;
	last_sel = 0;
	for (k = 0; k < BUF_DEPTH; k++)
		reply[k] = '0;
	for (k = 0; k < REC_W*MAX_REC; k++)
		recs[k] = '0;
	$readmemh("dv/spim_input.txt", recs);

	rst_n = 1'b0;
	repeat (8) @(posedge sclk_in);
	@(negedge sclk_in);
	rst_n = 1'b1;

	// reset values, then tx words read back over the bus
	errs0 = u_chk.err_cnt + tb_err;
	u_chk.verify_pins(4'hf, 1'b0);
	apb_access(1'b0, REG_STATUS, 32'h0, 1'b0);
	apb_access(1'b0, REG_CTRL, 32'h0, 1'b0);
	apb_access(1'b0, REG_BURST, 32'h1, 1'b0);
	apb_access(1'b1, TXBUF_BASE, 32'h5aa5c33c, 1'b0);
	apb_access(1'b1, TXBUF_BASE + apb_addr_t'(4*(BUF_DEPTH-1)), 32'h0ff0a55a, 1'b0);
	apb_access(1'b0, TXBUF_BASE, 32'h5aa5c33c, 1'b0);
	apb_access(1'b0, TXBUF_BASE + apb_addr_t'(4*(BUF_DEPTH-1)), 32'h0ff0a55a, 1'b0);
	if (u_chk.err_cnt + tb_err == errs0)
		n_pass++;
	else
		n_fail++;
	$display("test reset: %s", (u_chk.err_cnt + tb_err == errs0) ? "ok" : "error");

	for (r = 0; r < MAX_REC; r++) begin
		len = int'(recs[r*REC_W]);
		sel = int'(recs[r*REC_W+1]);
		if (len == 0)
			break;
		errs0 = u_chk.err_cnt + tb_err;
		for (k = 0; k < len; k++) begin
			if (k < 3) begin
				txw      = recs[r*REC_W+2+k];
				reply[k] = recs[r*REC_W+5+k];
			end else begin
				rng      = lcg_next(rng);
				txw      = rng;
				rng      = lcg_next(rng);
				reply[k] = rng;
			end
			u_chk.exp_mosi[k] = txw;
			apb_access(1'b1, TXBUF_BASE + apb_addr_t'(4*k), txw, 1'b0);
		end
		u_chk.arm(len, sel);
		apb_access(1'b1, REG_BURST, word_t'(len), 1'b0);
		apb_access(1'b1, REG_CTRL, word_t'((sel << CTRL_SSEL_LSB) | 1), 1'b0);
		// busy now, neither the start nor the other select may take effect
		apb_access(1'b1, REG_CTRL, word_t'((((sel + 1) % 4) << CTRL_SSEL_LSB) | 1), 1'b0);
		wait_irq(DATA_W * len + 40);
		@(negedge sclk_in);
		u_chk.verify_pins(4'hf, 1'b1);
		u_chk.expect_bursts(1);
		for (k = 0; k < len; k++)
			apb_access(1'b0, RXBUF_BASE + apb_addr_t'(4*k), reply[k], 1'b0);
		apb_access(1'b0, REG_STATUS, 32'h2, 1'b0);
		apb_access(1'b1, REG_STATUS, 32'h2, 1'b0);	// clear done
		apb_access(1'b0, REG_STATUS, 32'h0, 1'b0);
		u_chk.verify_pins(4'hf, 1'b0);
		last_len = len;
		last_sel = sel;
		if (u_chk.err_cnt + tb_err == errs0)
			n_pass++;
		else
			n_fail++;
		$display("test burst %0d len %0d sel %0d: %s", r, len, sel,
			(u_chk.err_cnt + tb_err == errs0) ? "ok" : "error");
	end

	// error responses leave the registers alone
	errs0 = u_chk.err_cnt + tb_err;
	apb_access(1'b0, 8'h0c, 32'h0, 1'b1);
	apb_access(1'b0, TXBUF_BASE + 8'h01, 32'h0, 1'b1);
	apb_access(1'b1, RXBUF_BASE, 32'hdeadbeef, 1'b1);
	apb_access(1'b1, 8'hc0, 32'h7, 1'b1);
	apb_access(1'b0, REG_CTRL, word_t'(last_sel << CTRL_SSEL_LSB), 1'b0);
	apb_access(1'b0, REG_BURST, word_t'(last_len), 1'b0);
	apb_access(1'b0, REG_STATUS, 32'h0, 1'b0);
	apb_access(1'b0, RXBUF_BASE, reply[0], 1'b0);
	if (u_chk.err_cnt + tb_err == errs0)
		n_pass++;
	else
		n_fail++;
	$display("test errors: %s", (u_chk.err_cnt + tb_err == errs0) ? "ok" : "error");

	$display("tests %0d passed %0d failed %0d", n_pass + n_fail, n_pass, n_fail);
	if (n_fail == 0 && u_chk.err_cnt == 0 && tb_err == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

endmodule

/* verilog.f */
design/spim_types_pkg.sv
design/spim_regs_pkg.sv
design/spim_apb_regs.sv
design/spim_word_buf.sv
design/spim_intf.sv
design/spim_top.sv
dv/spim_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
( verilator --binary --timing -Wno-fatal --top-module tb_top -f verilog.f -o tb_top \
	&& ./obj_dir/tb_top ) > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

/* dv/spim_input.txt */
// one record per line: burst_len sselect tx0 tx1 tx2 reply0 reply1 reply2
// words from index 3 up come from the LCG, a zero burst length ends the list
0001 0000 a5a5a5a5 00000000 00000000 3c3c3c3c 00000000 00000000
0003 0001 12345678 ffffffff 80000001 cafef00d 0f0f0f0f 55aa55aa
0002 0002 00000000 deadbeef 00000000 13579bdf 2468ace0 00000000
0010 0003 01020304 89abcdef fedcba98 11111111 22222222 33333333
0004 0000 00000001 80000000 7fffffff fffffffe 00000001 c3c3c3c3
0000 0000 00000000 00000000 00000000 00000000 00000000 00000000
